/* filelist.f */
+incdir+source
source/mul_pkg.sv
source/mul_lane_if.sv
source/mul_lane.sv
source/mul_dispatch.sv
source/mul_collect.sv
source/mul_farm.sv
test/mul_farm_tb.sv

/* test/mul_farm_tb.sv */
/* directed testbench for the multiply farm, credit-aware producer and consumer
   results are scored by tag against a behavioral product model */

`timescale 1ns/1ps

`include "mul_settings.svh"

module mul_farm_tb import mul_pkg::*; ();

  localparam int W = `MUL_WIDTH;
  localparam int N_LANES = `MUL_LANES;
  localparam int DEPTH = `MUL_REQ_DEPTH;
  localparam int N_TAGS = 2 ** `MUL_TAG_W;
  localparam int CREDIT_TIMEOUT = 200;
  localparam int RESP_TIMEOUT = 400;

  logic                  clk;
  logic                  reset;
  logic                  req_valid;
  mul_op_e               req_op;
  logic [W-1:0]          req_a;
  logic [W-1:0]          req_b;
  logic [`MUL_TAG_W-1:0] req_tag;
  logic                  req_credit;
  logic                  resp_credit;
  logic                  resp_valid;
  logic [2*W-1:0]        resp_result;
  logic [`MUL_TAG_W-1:0] resp_tag;

  // scoreboard, indexed by tag
  mul_resp_t exp_resp [N_TAGS];
  logic      pending  [N_TAGS];
  mul_resp_t rx_q [$];

  int seed = 36;
  int errors = 0;
  int timeouts = 0;
  int checks = 0;
  // producer credits and pulse / grant bookkeeping
  int prod_credits = DEPTH;
  int credit_pulses = 0;
  int resp_granted = 0;
  int resp_received = 0;

  mul_farm mul_farm_inst (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_tag     (req_tag),
    .req_credit  (req_credit),
    .resp_credit (resp_credit),
    .resp_valid  (resp_valid),
    .resp_result (resp_result),
    .resp_tag    (resp_tag)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // monitors
  // --------------------

  // a credit pulse counts on the edge that ends it, the queue entry has left by then
  always @(posedge clk) begin
    if (!reset && req_credit) begin
      credit_pulses++;
      prod_credits++;
    end
    if (!reset && resp_valid) begin
      rx_q.push_back('{result: resp_result, tag: resp_tag});
      resp_received++;
    end
  end

  // --------------------
  // reference model
  // --------------------

  // full-width product straight from the opcode's meaning
  function automatic logic [2*W-1:0] expected_product(input mul_op_e op,
                                                      input logic [W-1:0] a,
                                                      input logic [W-1:0] b);
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    logic [2*W-1:0]        ua;
    logic [2*W-1:0]        ub;
    sa = {{W{a[W-1]}}, a};
    sb = {{W{b[W-1]}}, b};
    ua = {{W{1'b0}}, a};
    ub = {{W{1'b0}}, b};
    if (op == OP_MUL) begin
      return sa * sb;
    end
    return ua * ub;
  endfunction

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_result(input mul_resp_t got, input mul_resp_t exp);
    checks++;
    if (got.result !== exp.result) begin
      errors++;
      $display("mismatch at %0t: resp_result (tag %0d) got %h expected %h",
               $time, exp.tag, got.result, exp.result);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    checks++;
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timeouts++;
    $display("error at %0t: timed out waiting for %s", $time, what);
  endtask

  // --------------------
  // producer and consumer
  // --------------------

  // waits for a credit, drives one valid cycle and records the expected result
  task automatic send_request(input mul_op_e op, input logic [W-1:0] a,
                              input logic [W-1:0] b, input logic [`MUL_TAG_W-1:0] tag);
    int t;
    t = 0;
    while (prod_credits == 0 && t < CREDIT_TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (prod_credits == 0) begin
      report_timeout("a request credit");
    end else begin
      exp_resp[tag] = '{result: expected_product(op, a, b), tag: tag};
      pending[tag] = 1'b1;
      prod_credits--;
      req_valid = 1'b1;
      req_op = op;
      req_a = a;
      req_b = b;
      req_tag = tag;
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  // one response credit per cycle
  task automatic grant_credits(input int n);
    repeat (n) begin
      resp_credit = 1'b1;
      resp_granted++;
      @(negedge clk);
    end
    resp_credit = 1'b0;
  endtask

  // top up the collector so that n more results can leave
  task automatic make_room(input int n);
    int need;
    need = n - (resp_granted - resp_received);
    if (need > 0) begin
      grant_credits(need);
    end
  endtask

  task automatic score_response(input mul_resp_t got);
    if (!pending[got.tag]) begin
      errors++;
      $display("error at %0t: result with tag %0d was not expected", $time, got.tag);
    end else begin
      check_result(got, exp_resp[got.tag]);
      pending[got.tag] = 1'b0;
    end
  endtask

  // waits for n results in any order, then scores them by tag
  task automatic wait_results(input int n);
    int t;
    t = 0;
    while (rx_q.size() < n && t < RESP_TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (rx_q.size() < n) begin
      report_timeout("results");
    end
    repeat (n) begin
      if (rx_q.size() > 0) begin
        score_response(rx_q.pop_front());
      end
    end
  endtask

  task automatic check_none_pending();
    for (int i = 0; i < N_TAGS; i++) begin
      if (pending[i]) begin
        errors++;
        $display("error at %0t: no result came back for tag %0d", $time, i);
        pending[i] = 1'b0;
      end
    end
  endtask

  // --------------------
  // directed tests
  // --------------------

  // outputs quiet after reset, even with response credits granted
  task automatic test_reset_quiet();
    for (int i = 0; i < 10; i++) begin
      resp_credit = (i % 3 == 1);
      if (resp_credit) begin
        resp_granted++;
      end
      @(negedge clk);
      check_bit(req_credit, 1'b0, "req_credit");
      check_bit(resp_valid, 1'b0, "resp_valid");
    end
    resp_credit = 1'b0;
  endtask

  task automatic test_signed_corners();
    make_room(7);
    send_request(OP_MUL, 32'd0, 32'd12345, 4'd0);
    send_request(OP_MUL, 32'd1, -32'sd7, 4'd1);
    send_request(OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 4'd2);
    // most negative value squared
    send_request(OP_MUL, 32'h8000_0000, 32'h8000_0000, 4'd3);
    send_request(OP_MUL, -32'sd5, 32'd7, 4'd4);
    send_request(OP_MUL, 32'd123456, -32'sd789, 4'd5);
    send_request(OP_MUL, 32'h7fff_ffff, 32'h8000_0000, 4'd6);
    wait_results(7);
    check_none_pending();
  endtask

  task automatic test_unsigned_corners();
    make_room(4);
    send_request(OP_MULU, 32'hffff_ffff, 32'hffff_ffff, 4'd0);
    send_request(OP_MULU, 32'h8000_0000, 32'hffff_ffff, 4'd1);
    send_request(OP_MULU, 32'hdead_beef, 32'hc0ff_ee00, 4'd2);
    send_request(OP_MULU, 32'hffff_ffff, 32'd1, 4'd3);
    wait_results(4);
    check_none_pending();
  endtask

  task automatic test_random_burst();
    int base;
    logic [W-1:0] a;
    logic [W-1:0] b;
    mul_op_e op;
    base = credit_pulses;
    // credits first, otherwise finished lanes would stall the burst
    make_room(12);
    for (int i = 0; i < 12; i++) begin
      a = $random(seed);
      b = $random(seed);
      op = mul_op_e'($random(seed) & 1);
      send_request(op, a, b, i[`MUL_TAG_W-1:0]);
    end
    wait_results(12);
    check_none_pending();
    check_count(credit_pulses - base, 12, "req_credit pulses");
  endtask

  task automatic test_back_pressure();
    int base;
    int total;
    logic [W-1:0] a;
    logic [W-1:0] b;
    base = credit_pulses;
    total = N_LANES + DEPTH;
    for (int i = 0; i < total; i++) begin
      a = $random(seed);
      b = $random(seed);
      send_request((i % 2) ? OP_MULU : OP_MUL, a, b, i[`MUL_TAG_W-1:0]);
    end
    // every lane finishes and holds, nothing may leave
    repeat (80) begin
      @(negedge clk);
      check_bit(resp_valid, 1'b0, "resp_valid");
    end
    check_count(credit_pulses - base, N_LANES, "req_credit pulses under back-pressure");
    check_count(rx_q.size(), 0, "results without credit");
    // one grant, one result
    for (int i = 0; i < total; i++) begin
      grant_credits(1);
      wait_results(1);
      repeat (4) @(negedge clk);
      check_count(rx_q.size(), 0, "extra results after one grant");
    end
    check_none_pending();
  endtask

  // lower bound only, measured in rising edges from the request edge
  task automatic test_min_latency();
    int lat;
    make_room(1);
    send_request(OP_MUL, 32'd3, 32'd5, 4'd9);
    lat = 1;
    while (!resp_valid && lat < RESP_TIMEOUT) begin
      @(negedge clk);
      lat++;
    end
    if (!resp_valid) begin
      report_timeout("the single result");
    end else begin
      checks++;
      if (lat < 36) begin
        errors++;
        $display("error at %0t: result came after %0d cycles, below the 36-cycle minimum",
                 $time, lat);
      end
    end
    wait_results(1);
    check_none_pending();
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    reset = 1'b1;
    req_valid = 1'b0;
    req_op = OP_MUL;
    req_a = '0;
    req_b = '0;
    req_tag = '0;
    resp_credit = 1'b0;
    for (int i = 0; i < N_TAGS; i++) begin
      pending[i] = 1'b0;
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;

    test_reset_quiet();
    test_signed_corners();
    test_unsigned_corners();
    test_random_burst();
    test_back_pressure();
    test_min_latency();

    repeat (4) @(negedge clk);
    $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* source/mul_farm.sv */
/* multiply farm top level, plain credit-handshake ports on both sides
   dispatcher, a row of identical lanes and the collector, joined by lane interfaces */

`timescale 1ns/1ps

`include "mul_settings.svh"

module mul_farm import mul_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,

  // request side, producer spends one credit per valid cycle
  input  logic                      req_valid,
  input  mul_op_e                   req_op,
  input  logic [`MUL_WIDTH-1:0]     req_a,
  input  logic [`MUL_WIDTH-1:0]     req_b,
  input  logic [`MUL_TAG_W-1:0]     req_tag,
  output logic                      req_credit,

  // response side, one result per granted credit
  input  logic                      resp_credit,
  output logic                      resp_valid,
  output logic [2*`MUL_WIDTH-1:0]   resp_result,
  output logic [`MUL_TAG_W-1:0]     resp_tag
);

  mul_req_t  req_pkt;
  mul_resp_t resp_pkt;

  // one link per lane
  mul_lane_if lane_if [`MUL_LANES] ();

  // pack request ports, unpack the response
  assign req_pkt     = '{op: req_op, a: req_a, b: req_b, tag: req_tag};
  assign resp_result = resp_pkt.result;
  assign resp_tag    = resp_pkt.tag;

  // --------------------
  // queue and lane pick
  // --------------------

  mul_dispatch dispatch_inst (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req_pkt),
    .req_credit (req_credit),
    .lanes      (lane_if)
  );

  // identical multiplier lanes
  for (genvar i = 0; i < `MUL_LANES; i++) begin : g_lane
    mul_lane lane_inst (
      .clk   (clk),
      .reset (reset),
      .lane  (lane_if[i])
    );
  end

  // --------------------
  // result drain
  // --------------------

  mul_collect collect_inst (
    .clk         (clk),
    .reset       (reset),
    .resp_credit (resp_credit),
    .lanes       (lane_if),
    .resp_valid  (resp_valid),
    .resp        (resp_pkt)
  );

endmodule

/* source/mul_collect.sv */
/* drains finished lanes round-robin, one result per response credit
   result and valid are registered, one cycle after the lane is taken */

`timescale 1ns/1ps

`include "mul_settings.svh"

module mul_collect import mul_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        resp_credit,
  mul_lane_if.collect lanes [`MUL_LANES],
  output logic        resp_valid,
  output mul_resp_t   resp
);

  localparam int N = `MUL_LANES;
  localparam int LANE_W = (N > 1) ? $clog2(N) : 1;
  // room for up to 255 outstanding grants
  localparam int CRD_W = 8;

  logic [CRD_W-1:0] credit;

  logic [N-1:0] done_vec;
  mul_resp_t    resp_arr [N];

  // last lane served, search starts just past it
  logic [LANE_W-1:0] last;
  logic [LANE_W-1:0] pick;
  logic              pick_valid;
  logic              take;

  for (genvar i = 0; i < N; i++) begin : g_lane
    assign done_vec[i]    = lanes[i].done;
    assign resp_arr[i]    = lanes[i].resp;
    assign lanes[i].taken = take && (pick == LANE_W'(i));

    // collector must not pull a lane that has nothing
    taken_only_done: assert property (
      @(posedge clk) disable iff (reset) lanes[i].taken |-> lanes[i].done
    ) else $error("taken raised on a lane that is not done");
  end

  // --------------------
  // round-robin pick
  // --------------------

  always_comb begin
    int idx;
    pick       = '0;
    pick_valid = 1'b0;
    idx        = 0;
    // first done lane after last, wrapping around
    for (int k = 1; k <= N; k++) begin
      idx = (int'(last) + k) % N;
      if (!pick_valid && done_vec[idx]) begin
        pick       = LANE_W'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  // nothing leaves without a credit
  assign take = pick_valid && (credit != '0);

  // --------------------
  // credits and pointer
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      credit     <= '0;
      last       <= LANE_W'(N - 1);
      resp_valid <= 1'b0;
    end else begin
      unique case ({resp_credit, take})
        2'b10:   credit <= credit + 1'b1;
        2'b01:   credit <= credit - 1'b1;
        default: credit <= credit;
      endcase
      if (take) begin
        last <= pick;
      end
      resp_valid <= take;
    end
  end

  // output payload, valid only with resp_valid
  always_ff @(posedge clk) begin
    if (take) begin
      resp <= resp_arr[pick];
    end
  end

  // no credit and no grant, so the counter holds at zero and no result leaves
  credit_no_underflow: assert property (
    @(posedge clk) disable iff (reset)
    credit == '0 && !resp_credit |=> credit == '0 && !resp_valid
  ) else $error("response credit counter underflow");

endmodule

/* source/mul_dispatch.sv */
/* request queue in front of the lanes, credit returned per entry sent
   the queue head goes to the lowest-numbered idle lane, one per cycle */

`timescale 1ns/1ps

`include "mul_settings.svh"

module mul_dispatch import mul_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         req_valid,
  input  mul_req_t     req,
  output logic         req_credit,
  mul_lane_if.dispatch lanes [`MUL_LANES]
);

  localparam int N = `MUL_LANES;
  localparam int D = `MUL_REQ_DEPTH;
  localparam int LANE_W = (N > 1) ? $clog2(N) : 1;
  localparam int PTR_W = (D > 1) ? $clog2(D) : 1;
  localparam int CNT_W = $clog2(D + 1);

  // circular queue, payload only
  mul_req_t queue [D];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             q_full;
  logic             q_empty;
  logic             push;
  logic             pop;

  logic [N-1:0]      idle_vec;
  logic [LANE_W-1:0] pick;
  logic              pick_valid;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(D - 1)) ? '0 : p + 1'b1;
  endfunction

  assign q_full  = (count == CNT_W'(D));
  assign q_empty = (count == '0);

  // --------------------
  // lane pick
  // --------------------

  // lowest idle lane wins, scan from the top down
  always_comb begin
    pick       = '0;
    pick_valid = 1'b0;
    for (int i = N - 1; i >= 0; i--) begin
      if (idle_vec[i]) begin
        pick       = LANE_W'(i);
        pick_valid = 1'b1;
      end
    end
  end

  assign push = req_valid && !q_full;
  assign pop  = !q_empty && pick_valid;

  // one credit back per entry leaving for a lane
  assign req_credit = pop;

  for (genvar i = 0; i < N; i++) begin : g_lane
    assign idle_vec[i]    = lanes[i].idle;
    assign lanes[i].start = pop && (pick == LANE_W'(i));
    // every lane sees the head, only the started one latches it
    assign lanes[i].req   = queue[rd_ptr];
  end

  // --------------------
  // queue storage and pointers
  // --------------------

  always_ff @(posedge clk) begin
    if (push) begin
      queue[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // producer has spent more credits than it was given
  no_push_when_full: assert property (
    @(posedge clk) disable iff (reset) req_valid |-> !q_full
  ) else $error("request arrived with the queue full, credit rule broken");

endmodule

/* source/mul_lane.sv */
/* one iterative shift-and-add multiplier lane, signed or unsigned by opcode
   started by the dispatcher, holds its product in ST_DONE until the collector takes it */

`timescale 1ns/1ps

`include "mul_settings.svh"

module mul_lane import mul_pkg::*; (
  input logic      clk,
  input logic      reset,
  mul_lane_if.lane lane
);

  localparam int W = `MUL_WIDTH;
  // counts 0..W, the last step registers the product
  localparam int CNT_W = $clog2(W + 1);

  mul_state_e state;
  logic [CNT_W-1:0] count;

  // latched at start
  mul_op_e               op_reg;
  logic                  sign_reg;
  logic [`MUL_TAG_W-1:0] tag_reg;

  // shift registers and running sum
  logic [2*W-1:0] a_reg;
  logic [W-1:0]   b_reg;
  logic [2*W-1:0] acc;
  logic [2*W-1:0] result_reg;

  logic           is_signed;
  logic [W-1:0]   a_in;
  logic [W-1:0]   b_in;
  logic [2*W-1:0] acc_next;
  logic           last_step;

  // --------------------
  // operand prep
  // --------------------

  // signed op works on magnitudes, sign put back at the end
  assign is_signed = (lane.req.op == OP_MUL);
  assign a_in = (is_signed && lane.req.a[W-1]) ? (~lane.req.a + 1'b1) : lane.req.a;
  assign b_in = (is_signed && lane.req.b[W-1]) ? (~lane.req.b + 1'b1) : lane.req.b;

  // add the shifted a only where b has a one
  assign acc_next = b_reg[0] ? (acc + a_reg) : acc;

  // all W iterations are in acc
  assign last_step = (count == CNT_W'(W));

  // --------------------
  // control FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      unique case (state)
        ST_IDLE: begin
          if (lane.start) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          // W shift-add steps, then one step to fix the sign
          if (last_step) begin
            state <= ST_DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        ST_DONE: begin
          // hold until collector takes it
          if (lane.taken) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && lane.start) begin
      op_reg   <= lane.req.op;
      tag_reg  <= lane.req.tag;
      sign_reg <= lane.req.a[W-1] ^ lane.req.b[W-1];
      a_reg    <= {{W{1'b0}}, a_in};
      b_reg    <= b_in;
      acc      <= '0;
    end else if (state == ST_CALC) begin
      if (last_step) begin
        // sign only matters for the signed opcode
        result_reg <= (op_reg == OP_MUL && sign_reg) ? (~acc + 1'b1) : acc;
      end else begin
        acc   <= acc_next;
        a_reg <= a_reg << 1;
        b_reg <= b_reg >> 1;
      end
    end
  end

  // status and product back to the interface
  assign lane.idle = (state == ST_IDLE);
  assign lane.done = (state == ST_DONE);
  assign lane.resp = '{result: result_reg, tag: tag_reg};

  // --------------------
  // checks
  // --------------------

  // dispatcher must only start a lane that reports idle
  start_while_idle: assert property (
    @(posedge clk) disable iff (reset) lane.start |-> lane.idle
  ) else $error("lane started while busy");

  // product held steady until the collector takes it
  resp_held: assert property (
    @(posedge clk) disable iff (reset)
    lane.done && !lane.taken |=> lane.done && $stable(lane.resp)
  ) else $error("lane response changed before taken");

endmodule

/* source/mul_lane_if.sv */
/* link between one multiplier lane, the dispatcher and the collector
   one instance per lane, each side connects through its own modport */

`timescale 1ns/1ps

interface mul_lane_if import mul_pkg::*; ();

  // dispatcher to lane, start only while idle
  logic     start;
  mul_req_t req;

  // lane status
  logic idle;
  logic done;

  // product, held stable while done until taken
  mul_resp_t resp;

  // collector to lane, only while done
  logic taken;

  modport dispatch (
    output start,
    output req,
    input  idle
  );

  modport lane (
    input  start,
    input  req,
    input  taken,
    output idle,
    output done,
    output resp
  );

  modport collect (
    input  done,
    input  resp,
    output taken
  );

endinterface

/* source/mul_pkg.sv */
/* types shared by the multiply farm RTL and its testbench
   opcodes, lane states and the request / response payloads */

`include "mul_settings.svh"

package mul_pkg;

  // --------------------
  // opcodes
  // --------------------

  // signed x signed, or unsigned x unsigned
  typedef enum logic {
    OP_MUL  = 1'b0,
    OP_MULU = 1'b1
  } mul_op_e;

  // --------------------
  // lane control states
  // --------------------

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } mul_state_e;

  // --------------------
  // payloads
  // --------------------

  // one request as it sits in the queue and goes to a lane
  typedef struct packed {
    mul_op_e               op;
    logic [`MUL_WIDTH-1:0] a;
    logic [`MUL_WIDTH-1:0] b;
    logic [`MUL_TAG_W-1:0] tag;
  } mul_req_t;

  // full-width product plus the tag it came in with
  typedef struct packed {
    logic [2*`MUL_WIDTH-1:0] result;
    logic [`MUL_TAG_W-1:0]   tag;
  } mul_resp_t;

endpackage

/* source/mul_settings.svh */
/* sizes for the multiply farm, shared by the package, the RTL and the testbench
   include wherever one of the MUL_ macros is needed */

`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// number of identical multiplier lanes
`define MUL_LANES 4

// request queue depth, also the producer's starting credit count
`define MUL_REQ_DEPTH 4

// operand width, the product is twice this
`define MUL_WIDTH 32

// requester tag width
`define MUL_TAG_W 4

`endif
